//--- common/pixel_pkg.sv
// ======================================
// shared definitions of the pixel readout
// bus addresses, word tags, sizes, the
// sequence output bit map and the state
// and select enums
// ======================================

package pixel_pkg;

    // bus addresses, after the offset is removed
    localparam logic [15:0] bus_offset       = 16'h4000;
    localparam logic [15:0] seq_gen_baseaddr = 16'h1000;
    localparam logic [15:0] seq_ctrl_addr    = seq_gen_baseaddr;
    localparam logic [15:0] seq_len_addr     = seq_gen_baseaddr + 16'd1;
    localparam logic [15:0] seq_mem_addr     = seq_gen_baseaddr + 16'd16;
    localparam logic [15:0] tdc_baseaddr     = 16'h0200;

    // sequence memory
    localparam int seq_depth    = 64;
    localparam int seq_add_bits = $clog2(seq_depth);

    // sequence output bits
    localparam int seq_bit_sr_in         = 0;
    localparam int seq_bit_global_sr_en  = 1;
    localparam int seq_bit_global_ctr_ld = 2;
    localparam int seq_bit_global_dac_ld = 3;
    localparam int seq_bit_pixel_sr_en   = 4;
    localparam int seq_bit_inject        = 5;

    // data words
    localparam logic [3:0] spi_id = 4'b0001;
    localparam logic [3:0] tdc_id = 4'b0100;
    localparam int spi_word_bits  = 16;
    localparam int spi_cnt_bits   = $clog2(spi_word_bits);
    localparam int word_cnt_bits  = 12;

    // output buffer
    localparam int fifo_depth     = 16;
    localparam int fifo_near_full = 12;
    localparam int fifo_add_bits  = $clog2(fifo_depth);

    typedef enum logic {seq_idle, seq_run} seq_state_t;
    typedef enum logic [1:0] {seq_sel_ctrl, seq_sel_len, seq_sel_mem} seq_sel_t;
    typedef enum logic [1:0] {tdc_wait, tdc_count, tdc_emit} tdc_state_t;

endpackage

//--- seq_gen/seq_gen.sv
// ======================================
// sequence generator
// step memory with bus write port, length
// register and the playback FSM
// ======================================

`timescale 1ns/1ns

module seq_gen (
    input  logic                              bus_clk,
    input  logic                              rst,
    input  logic                              wr,
    input  logic [1:0]                        wr_sel,
    input  logic [pixel_pkg::seq_add_bits-1:0] wr_add,
    input  logic [7:0]                        wr_data,
    output logic [7:0]                        seq_out,
    output logic                              busy
);

    logic [7:0] mem [pixel_pkg::seq_depth];

    pixel_pkg::seq_state_t state;

    logic [pixel_pkg::seq_add_bits-1:0] step;
    logic [pixel_pkg::seq_add_bits-1:0] last_q;
    logic start;
    logic len_wr;

    assign start  = wr && wr_sel == pixel_pkg::seq_sel_ctrl && wr_data[0];
    assign len_wr = wr && wr_sel == pixel_pkg::seq_sel_len;
    assign busy   = state == pixel_pkg::seq_run;

    // step memory, written from the bus at any time
    always_ff @(posedge bus_clk) begin
        if (wr && wr_sel == pixel_pkg::seq_sel_mem) begin
            mem[wr_add] <= wr_data;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            state   <= pixel_pkg::seq_idle;
            step    <= '0;
            last_q  <= '1;
            seq_out <= '0;
        end else begin
            // keep last step index; a length of 64 wraps to index 63
            if (len_wr && !busy) begin
                last_q <= wr_data[pixel_pkg::seq_add_bits-1:0] - 1'b1;
            end

            case (state)
                pixel_pkg::seq_idle: begin
                    seq_out <= '0;
                    step    <= '0;
                    if (start) begin
                        state <= pixel_pkg::seq_run;
                    end
                end
                pixel_pkg::seq_run: begin
                    // one step per cycle
                    seq_out <= mem[step];
                    step    <= step + 1'b1;
                    if (step == last_q) begin
                        state <= pixel_pkg::seq_idle;
                    end
                end
                default: begin
                    state <= pixel_pkg::seq_idle;
                end
            endcase
        end
    end

endmodule

//--- tdc/tdc.sv
// ======================================
// HIT_OR pulse width measurement
// counts the high time in bus_clk cycles
// and holds one tagged word for readout
// ======================================

`timescale 1ns/1ns

module tdc (
    input  logic        bus_clk,
    input  logic        rst,
    input  logic        enable,
    input  logic        tdc_in,
    input  logic        fifo_read,
    output logic        fifo_empty,
    output logic [31:0] fifo_data
);

    pixel_pkg::tdc_state_t state;

    logic                               in_q;
    logic                               held;
    logic [15:0]                        hi_cnt;
    logic [pixel_pkg::word_cnt_bits-1:0] evt_cnt;

    assign fifo_empty = !held;

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            state   <= pixel_pkg::tdc_wait;
            in_q    <= 1'b0;
            held    <= 1'b0;
            hi_cnt  <= '0;
            evt_cnt <= '0;
        end else begin
            in_q <= tdc_in;
            if (fifo_read) begin
                held <= 1'b0;
            end

            case (state)
                pixel_pkg::tdc_wait: begin
                    // rising edge only, and only with the word register free
                    if (enable && tdc_in && !in_q && !held) begin
                        hi_cnt <= 16'd1;
                        state  <= pixel_pkg::tdc_count;
                    end
                end
                pixel_pkg::tdc_count: begin
                    if (!tdc_in) begin
                        state <= pixel_pkg::tdc_emit;
                    end else if (hi_cnt != 16'hffff) begin
                        hi_cnt <= hi_cnt + 1'b1;
                    end
                end
                pixel_pkg::tdc_emit: begin
                    held    <= 1'b1;
                    evt_cnt <= evt_cnt + 1'b1;
                    state   <= pixel_pkg::tdc_wait;
                end
                default: begin
                    state <= pixel_pkg::tdc_wait;
                end
            endcase
        end
    end

    // word: tag, event count, high time
    always_ff @(posedge bus_clk) begin
        if (state == pixel_pkg::tdc_emit) begin
            fifo_data <= {pixel_pkg::tdc_id, evt_cnt, hi_cnt};
        end
    end

endmodule

//--- verilog/spi_rx.sv
// ======================================
// pixel shift-register receiver
// deserializes sdi while sen is high and
// holds one tagged word for readout
// ======================================

`timescale 1ns/1ns

module spi_rx (
    input  logic        bus_clk,
    input  logic        rst,
    input  logic        sen,
    input  logic        sdi,
    input  logic        fifo_read,
    output logic        fifo_empty,
    output logic [31:0] fifo_data
);

    logic [pixel_pkg::spi_word_bits-1:0] sr;
    logic [pixel_pkg::spi_word_bits-1:0] sr_next;
    logic [pixel_pkg::spi_cnt_bits-1:0]  bit_cnt;
    logic [pixel_pkg::word_cnt_bits-1:0] word_cnt;
    logic                               held;
    logic                               done;
    logic                               load;

    // first sampled bit ends up as the MSB
    assign sr_next = {sr[pixel_pkg::spi_word_bits-2:0], sdi};
    assign done    = sen && bit_cnt == pixel_pkg::spi_cnt_bits'(pixel_pkg::spi_word_bits - 1);

    // a word completing while the old one is still held is dropped
    assign load       = done && (!held || fifo_read);
    assign fifo_empty = !held;

    always_ff @(posedge bus_clk) begin
        if (sen) begin
            sr <= sr_next;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            bit_cnt  <= '0;
            word_cnt <= '0;
            held     <= 1'b0;
        end else begin
            if (sen) begin
                bit_cnt <= done ? '0 : bit_cnt + 1'b1;
            end
            if (load) begin
                held     <= 1'b1;
                word_cnt <= word_cnt + 1'b1;
            end else if (fifo_read) begin
                held <= 1'b0;
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        if (load) begin
            fifo_data <= {pixel_pkg::spi_id, word_cnt, sr_next};
        end
    end

endmodule

//--- verilog/rr_arbiter.sv
// ======================================
// round-robin merge of two word sources
// combinational grant, registered write
// toward the output FIFO
// ======================================

`timescale 1ns/1ns

module rr_arbiter (
    input  logic        bus_clk,
    input  logic        rst,
    input  logic [1:0]  req,
    input  logic [31:0] data_in0,
    input  logic [31:0] data_in1,
    input  logic        full,
    output logic [1:0]  grant,
    output logic        wr_en,
    output logic [31:0] wr_data
);

    // source granted most recently
    logic last;

    // at most one word in flight, so full is up to date at the next grant
    always_comb begin
        grant = 2'b00;
        if (!full && !wr_en) begin
            if (req[0] && (!req[1] || last)) begin
                grant = 2'b01;
            end else if (req[1]) begin
                grant = 2'b10;
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            last  <= 1'b1;
            wr_en <= 1'b0;
        end else begin
            wr_en <= |grant;
            if (|grant) begin
                last <= grant[1];
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        if (|grant) begin
            wr_data <= grant[1] ? data_in1 : data_in0;
        end
    end

endmodule

//--- verilog/out_fifo.sv
// ======================================
// output word FIFO
// 16 x 32 RAM, first-word fall-through
// read, fill count and near-full flag
// ======================================

`timescale 1ns/1ns

module out_fifo (
    input  logic        bus_clk,
    input  logic        rst,
    input  logic        wr_en,
    input  logic [31:0] wr_data,
    input  logic        rd_en,
    output logic [31:0] rd_data,
    output logic        empty,
    output logic        full,
    output logic        near_full
);

    logic [31:0] mem [pixel_pkg::fifo_depth];

    logic [pixel_pkg::fifo_add_bits-1:0] wr_ptr;
    logic [pixel_pkg::fifo_add_bits-1:0] rd_ptr;
    logic [pixel_pkg::fifo_add_bits:0]   count;
    logic                               do_wr;
    logic                               do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign empty     = count == '0;
    assign full      = count == (pixel_pkg::fifo_add_bits + 1)'(pixel_pkg::fifo_depth);
    assign near_full = count >= (pixel_pkg::fifo_add_bits + 1)'(pixel_pkg::fifo_near_full);

    // head word visible without a read cycle
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge bus_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- verilog/usb_reader.sv
// ======================================
// host read port
// splits buffered words into bytes, LSB
// first, on fread with fstrobe
// ======================================

`timescale 1ns/1ns

module usb_reader (
    input  logic        bus_clk,
    input  logic        rst,
    input  logic        fifo_empty,
    input  logic [31:0] fifo_data,
    input  logic        fread,
    input  logic        fstrobe,
    output logic        fifo_rd,
    output logic [7:0]  fd,
    output logic        fifo_not_empty
);

    logic [31:0] word;
    logic [1:0]  idx;
    logic        held;
    logic        adv;

    assign adv = held && fread && fstrobe;

    // refill when idle or when the last byte goes out
    assign fifo_rd        = !fifo_empty && (!held || (adv && idx == 2'd3));
    assign fd             = held ? word[idx*8 +: 8] : 8'h00;
    assign fifo_not_empty = held;

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            held <= 1'b0;
            idx  <= 2'd0;
        end else if (fifo_rd) begin
            held <= 1'b1;
            idx  <= 2'd0;
        end else if (adv) begin
            if (idx == 2'd3) begin
                held <= 1'b0;
            end
            idx <= idx + 1'b1;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (fifo_rd) begin
            word <= fifo_data;
        end
    end

endmodule

//--- verilog/pixel.sv
// ======================================
// pixel readout top level
// bus decode, TDC enable register, chip
// control split and block wiring
// ======================================

`timescale 1ns/1ns

module pixel (
    input  logic        bus_clk,
    input  logic        rst,
    input  logic [15:0] add,
    input  logic [7:0]  bus_data,
    input  logic        wr_b,
    input  logic        fread,
    input  logic        fstrobe,
    input  logic        pixel_sr_out,
    input  logic        hit_or,
    output logic [7:0]  fd,
    output logic        fifo_not_empty,
    output logic        sr_in,
    output logic        global_sr_clk,
    output logic        global_ctr_ld,
    output logic        global_dac_ld,
    output logic        pixel_sr_clk,
    output logic        inject,
    output logic        led1
);

    logic [15:0] bus_add;
    logic [15:0] mem_off;
    logic        bus_wr;
    logic        seq_wr;
    logic [1:0]  seq_sel;
    logic        tdc_en;
    logic [7:0]  seq_out;

    logic        spi_empty, spi_read, tdc_empty, tdc_read;
    logic [31:0] spi_data, tdc_data, arb_data, fifo_data;
    logic [1:0]  grant;
    logic        arb_wr, fifo_full, fifo_empty, fifo_rd, near_full;

    assign bus_add = add - pixel_pkg::bus_offset;
    assign bus_wr  = ~wr_b;

    // below the memory base this wraps to a large value
    assign mem_off = bus_add - pixel_pkg::seq_mem_addr;

    always_comb begin
        seq_wr  = 1'b0;
        seq_sel = pixel_pkg::seq_sel_ctrl;
        if (bus_add == pixel_pkg::seq_ctrl_addr) begin
            seq_wr = bus_wr;
        end else if (bus_add == pixel_pkg::seq_len_addr) begin
            seq_wr  = bus_wr;
            seq_sel = pixel_pkg::seq_sel_len;
        end else if (mem_off < 16'(pixel_pkg::seq_depth)) begin
            seq_wr  = bus_wr;
            seq_sel = pixel_pkg::seq_sel_mem;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            tdc_en <= 1'b0;
        end else if (bus_wr && bus_add == pixel_pkg::tdc_baseaddr) begin
            tdc_en <= bus_data[0];
        end
    end

    // chip controls; enable bits leave as one-cycle clock pulses
    assign sr_in         = seq_out[pixel_pkg::seq_bit_sr_in];
    assign global_sr_clk = seq_out[pixel_pkg::seq_bit_global_sr_en];
    assign global_ctr_ld = seq_out[pixel_pkg::seq_bit_global_ctr_ld];
    assign global_dac_ld = seq_out[pixel_pkg::seq_bit_global_dac_ld];
    assign pixel_sr_clk  = seq_out[pixel_pkg::seq_bit_pixel_sr_en];
    assign inject        = seq_out[pixel_pkg::seq_bit_inject];
    assign led1          = near_full;

    assign {spi_read, tdc_read} = grant;

    seq_gen i_seq_gen (
        .bus_clk(bus_clk), .rst(rst), .wr(seq_wr), .wr_sel(seq_sel),
        .wr_add(mem_off[pixel_pkg::seq_add_bits-1:0]), .wr_data(bus_data),
        .seq_out(seq_out), .busy()
    );

    spi_rx i_spi_rx (
        .bus_clk(bus_clk), .rst(rst), .sen(pixel_sr_clk), .sdi(pixel_sr_out),
        .fifo_read(spi_read), .fifo_empty(spi_empty), .fifo_data(spi_data)
    );

    tdc i_tdc (
        .bus_clk(bus_clk), .rst(rst), .enable(tdc_en), .tdc_in(hit_or),
        .fifo_read(tdc_read), .fifo_empty(tdc_empty), .fifo_data(tdc_data)
    );

    rr_arbiter i_rr_arbiter (
        .bus_clk(bus_clk), .rst(rst), .req({~spi_empty, ~tdc_empty}),
        .data_in0(tdc_data), .data_in1(spi_data), .full(fifo_full),
        .grant(grant), .wr_en(arb_wr), .wr_data(arb_data)
    );

    out_fifo i_out_fifo (
        .bus_clk(bus_clk), .rst(rst), .wr_en(arb_wr), .wr_data(arb_data),
        .rd_en(fifo_rd), .rd_data(fifo_data), .empty(fifo_empty),
        .full(fifo_full), .near_full(near_full)
    );

    usb_reader i_usb_reader (
        .bus_clk(bus_clk), .rst(rst), .fifo_empty(fifo_empty),
        .fifo_data(fifo_data), .fread(fread), .fstrobe(fstrobe),
        .fifo_rd(fifo_rd), .fd(fd), .fifo_not_empty(fifo_not_empty)
    );

endmodule

//--- testbench/pixel_assert.sv
// ========================================
// concurrent checks on the output FIFO
// and the round-robin arbiter, attached
// with bind
// ========================================

`timescale 1ns/1ns

module pixel_assert (
    input logic       bus_clk,
    input logic       rst,
    input logic       wr_en,
    input logic       full,
    input logic [1:0] grant,
    input logic       near_full,
    input logic       empty
);

    int failures = 0;

    // a write into a full buffer would be lost
    wr_while_full: assert property (@(posedge bus_clk) disable iff (rst) !(wr_en && full))
        else begin
            failures++;
            $error("write strobe while the output FIFO is full");
        end

    grant_onehot: assert property (@(posedge bus_clk) disable iff (rst) $onehot0(grant))
        else begin
            failures++;
            $error("arbiter granted both sources in one cycle");
        end

    near_full_not_empty: assert property (
        @(posedge bus_clk) disable iff (rst) near_full |-> !empty)
        else begin
            failures++;
            $error("near_full is high while the FIFO is empty");
        end

endmodule

bind pixel pixel_assert assert_i (
    .bus_clk(bus_clk), .rst(rst), .wr_en(arb_wr), .full(fifo_full),
    .grant(grant), .near_full(near_full), .empty(fifo_empty)
);

//--- testbench/pixel_checker.sv
// ========================================
// readout monitor
// predicts chip control steps and host
// words per tag, compares them with the
// DUT outputs and counts errors
// ========================================

`timescale 1ns/1ns

module pixel_checker (
    input logic       bus_clk,
    input logic       rst,
    input logic [7:0] fd,
    input logic       fifo_not_empty,
    input logic       fread,
    input logic       fstrobe,
    input logic       sr_in,
    input logic       global_sr_clk,
    input logic       global_ctr_ld,
    input logic       global_dac_ld,
    input logic       pixel_sr_clk,
    input logic       inject,
    input logic       led1
);

    logic [7:0]  seq_q [$];
    logic [31:0] spi_q [$];
    logic [31:0] tdc_q [$];
    logic [11:0] spi_cnt     = '0;
    logic [11:0] tdc_cnt     = '0;
    logic [31:0] word        = '0;
    int          nbytes      = 0;
    int          errors      = 0;
    int          outstanding = 0;
    int          words_seen  = 0;

    // one entry per cycle, zero when nothing is queued
    task automatic expect_step(input logic [7:0] step);
        seq_q.push_back(step);
    endtask

    // receiver word: tag, running count, pattern as shifted in
    task automatic expect_spi(input logic [15:0] pattern);
        spi_q.push_back({pixel_pkg::spi_id, spi_cnt, pattern});
        spi_cnt = spi_cnt + 12'd1;
        outstanding++;
    endtask

    task automatic expect_tdc(input logic [15:0] high_time);
        tdc_q.push_back({pixel_pkg::tdc_id, tdc_cnt, high_time});
        tdc_cnt = tdc_cnt + 12'd1;
        outstanding++;
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // order only holds within one tag
    task automatic match_word(input logic [31:0] w);
        words_seen++;
        if (w[31:28] == pixel_pkg::spi_id && spi_q.size() > 0) begin
            compare("receiver word", spi_q.pop_front(), w);
            outstanding--;
        end else if (w[31:28] == pixel_pkg::tdc_id && tdc_q.size() > 0) begin
            compare("TDC word", tdc_q.pop_front(), w);
            outstanding--;
        end else begin
            errors++;
            $display("host received word %h at %0t ns that no source should have sent",
                     w, $time);
        end
    endtask

    // sample in the middle of the cycle
    always @(negedge bus_clk) begin
        logic [7:0] step;
        step = 8'h00;
        if (seq_q.size() > 0) begin
            step = seq_q.pop_front();
        end
        compare("chip controls {inject..sr_in}", {26'd0, step[5:0]},
                {26'd0, inject, pixel_sr_clk, global_dac_ld, global_ctr_ld,
                 global_sr_clk, sr_in});
        if (rst) begin
            compare("led1", 32'd0, {31'd0, led1});
            compare("fifo_not_empty", 32'd0, {31'd0, fifo_not_empty});
        end
        if (fifo_not_empty !== 1'b1) begin
            compare("fd", 32'd0, {24'd0, fd});
        end else if (fread && fstrobe) begin
            // bytes arrive LSB first
            word[nbytes*8 +: 8] = fd;
            nbytes++;
            if (nbytes == 4) begin
                nbytes = 0;
                match_word(word);
            end
        end
    end

endmodule

//--- testbench/tb_pixel.sv
// ========================================
// pixel readout testbench top
// clock and reset, chip shift-register
// model, host read port, stimulus table
// and the row loop with bus writes
// ========================================

`timescale 1ns/1ns

module tb_pixel;

    typedef struct packed {
        logic [3:0]  pre;
        logic [3:0]  inj;
        logic [7:0]  width;
        logic        tdc_on;
        logic        stall;
        logic        led_high;
        logic [15:0] exp_time;
    } row_t;

    localparam int num_rows = 11;

    logic        bus_clk      = 1'b0;
    logic        rst;
    logic [15:0] add;
    logic [7:0]  bus_data;
    logic        wr_b;
    logic        fread        = 1'b0;
    logic        fstrobe      = 1'b0;
    logic        pixel_sr_out = 1'b0;
    logic        hit_or;
    logic [7:0]  fd;
    logic        fifo_not_empty;
    logic        sr_in;
    logic        global_sr_clk;
    logic        global_ctr_ld;
    logic        global_dac_ld;
    logic        pixel_sr_clk;
    logic        inject;
    logic        led1;

    logic        host_on      = 1'b0;
    logic [15:0] chip_pattern = '0;
    logic [3:0]  chip_bit     = '0;
    logic [7:0]  steps [64];
    int          timeouts     = 0;
    int          assert_fails;

    // pre, inj, width, tdc_on, stall, led_high, expected high time
    row_t rows [num_rows] = '{
        '{4'd2, 4'd2, 8'd3,  1'b1, 1'b0, 1'b0, 16'd3},
        '{4'd0, 4'd4, 8'd1,  1'b1, 1'b0, 1'b0, 16'd1},
        '{4'd3, 4'd0, 8'd7,  1'b0, 1'b0, 1'b0, 16'd0},
        '{4'd1, 4'd1, 8'd2,  1'b1, 1'b1, 1'b0, 16'd2},
        '{4'd0, 4'd2, 8'd5,  1'b1, 1'b1, 1'b0, 16'd5},
        '{4'd2, 4'd0, 8'd9,  1'b1, 1'b1, 1'b0, 16'd9},
        '{4'd1, 4'd3, 8'd4,  1'b1, 1'b1, 1'b0, 16'd4},
        '{4'd0, 4'd1, 8'd12, 1'b1, 1'b1, 1'b0, 16'd12},
        '{4'd2, 4'd2, 8'd6,  1'b1, 1'b1, 1'b0, 16'd6},
        '{4'd1, 4'd0, 8'd20, 1'b1, 1'b1, 1'b1, 16'd20},
        '{4'd1, 4'd1, 8'd8,  1'b1, 1'b0, 1'b0, 16'd8}
    };

    pixel pixel_i (.*);

    pixel_checker monitor_i (.*);

    always #5 bus_clk = ~bus_clk;

    // chip model shifts the next pattern bit, MSB first, while pixel_sr_clk is high
    always @(posedge bus_clk) begin
        #1;
        if (pixel_sr_clk) begin
            pixel_sr_out = chip_pattern[4'd15 - chip_bit];
            chip_bit     = chip_bit + 4'd1;
        end
    end

    // host side takes a byte on every other cycle
    always @(posedge bus_clk) begin
        #1;
        fread   = host_on;
        fstrobe = host_on && !fstrobe;
    end

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge bus_clk);
            #1;
        end
    endtask

    task automatic bus_write(input logic [15:0] local_add, input logic [7:0] data);
        add      = local_add + pixel_pkg::bus_offset;
        bus_data = data;
        wr_b     = 1'b0;
        @(posedge bus_clk);
        #1;
        wr_b     = 1'b1;
    endtask

    task automatic wait_led(input logic level);
        int n;
        n = 0;
        while (led1 !== level && n < 200) begin
            @(posedge bus_clk);
            #1;
            n++;
        end
        if (led1 !== level) begin
            timeouts++;
            $display("timeout at %0t ns: led1 did not go to %0b", $time, level);
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (monitor_i.outstanding != 0 && n < 1000) begin
            @(posedge bus_clk);
            #1;
            n++;
        end
        if (monitor_i.outstanding != 0) begin
            timeouts++;
            $display("timeout at %0t ns: %0d expected words never reached the host",
                     $time, monitor_i.outstanding);
        end
    endtask

    // setup steps, 16 shift steps, inject steps, then the load step
    task automatic build_steps(input row_t r, output int len);
        int n;
        n = 0;
        for (int i = 0; i < int'(r.pre); i++) begin
            steps[n] = (i % 2 == 0) ? 8'h03 : 8'h02;
            n++;
        end
        for (int i = 0; i < 16; i++) begin
            steps[n] = 8'h10;
            n++;
        end
        for (int i = 0; i < int'(r.inj); i++) begin
            steps[n] = (i % 2 == 0) ? 8'h20 : 8'h00;
            n++;
        end
        steps[n] = 8'h0c;
        len = n + 1;
    endtask

    task automatic run_row(input row_t r);
        int len;
        host_on = !r.stall;
        bus_write(pixel_pkg::tdc_baseaddr, {7'd0, r.tdc_on});
        build_steps(r, len);
        for (int i = 0; i < len; i++) begin
            bus_write(pixel_pkg::seq_mem_addr + 16'(i), steps[i]);
        end
        bus_write(pixel_pkg::seq_len_addr, 8'(len));
        chip_pattern = 16'($urandom);
        monitor_i.expect_spi(chip_pattern);
        // first step shows 2 cycles after the start write
        monitor_i.expect_step(8'h00);
        monitor_i.expect_step(8'h00);
        for (int i = 0; i < len; i++) begin
            monitor_i.expect_step(steps[i]);
        end
        bus_write(pixel_pkg::seq_ctrl_addr, 8'h01);
        wait_cycles(len + 2);
        if (r.tdc_on) begin
            monitor_i.expect_tdc(r.exp_time);
        end
        hit_or = 1'b1;
        wait_cycles(int'(r.width));
        hit_or = 1'b0;
        wait_cycles(4);
        if (r.led_high) begin
            wait_led(1'b1);
        end else begin
            // fewer than 12 buffered words keep the LED dark
            monitor_i.compare("led1", 32'd0, {31'd0, led1});
        end
    endtask

    initial begin
        void'($urandom(32'h0d71_7733));
        rst      = 1'b1;
        add      = '0;
        bus_data = '0;
        wr_b     = 1'b1;
        hit_or   = 1'b0;
        repeat (10) @(posedge bus_clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < num_rows; i++) begin
            run_row(rows[i]);
        end
        host_on = 1'b1;
        wait_drained();
        wait_led(1'b0);
        assert_fails = pixel_i.assert_i.failures;
        $display("results: %0d check errors, %0d assertion failures, %0d timeouts, %0d words",
                 monitor_i.errors, assert_fails, timeouts, monitor_i.words_seen);
        if (monitor_i.errors == 0 && assert_fails == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- project.f
common/pixel_pkg.sv
seq_gen/seq_gen.sv
tdc/tdc.sv
verilog/spi_rx.sv
verilog/rr_arbiter.sv
verilog/out_fifo.sv
verilog/usb_reader.sv
verilog/pixel.sv
testbench/pixel_assert.sv
testbench/pixel_checker.sv
testbench/tb_pixel.sv

//--- Makefile
# Verilator flow for the pixel readout testbench

TOP := tb_pixel

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

# pass only if the log holds the pass line
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
